//--- Makefile
TOP = tb_router_node

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f sources.f

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 --top-module $(TOP) -f sources.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

//--- flit_fifo.sv
// Input link flit FIFO

`timescale 1ns/1ps

module flit_fifo #(
	parameter int DEPTH = 4
) (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic                        push,
	input  logic [noc_flit_pkg::FLIT_W-1:0] push_flit,
	output logic                        in_ready,
	input  logic                        pop,
	output logic [noc_flit_pkg::FLIT_W-1:0] head_flit,
	output logic                        not_empty
);

	import noc_flit_pkg::*;

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [FLIT_W-1:0] mem [DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [CNT_W-1:0]  count;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Status and read port
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign not_empty = (count != '0);
	assign in_ready  = (count != CNT_W'(DEPTH)); // Full blocks the link
	assign head_flit = mem[rd_ptr];              // Head shows up the cycle after a write

	// Storage array
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= push_flit;
		end
	end

	// Pointers and occupancy
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Idle or simultaneous read and write
			endcase
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checks on the link and controller sides
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Writer must respect in_ready
	a_no_push_full: assert property (
		@(posedge clk) disable iff (!arst_n) push |-> in_ready
	) else $error("flit_fifo: push while full");

	// Route controller must not read an empty buffer
	a_no_pop_empty: assert property (
		@(posedge clk) disable iff (!arst_n) pop |-> not_empty
	) else $error("flit_fifo: pop while empty");

endmodule

//--- noc_flit_pkg.sv
// Flit format definitions

package noc_flit_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Flit layout
	//   [10]   tail marker
	//   [9:0]  field, signed hop count in a head flit
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int FLIT_W   = 11;
	localparam int HOP_W    = 10;
	localparam int HOP_LSB  = 0;
	localparam int TAIL_BIT = 10;

	// Tail marker of any flit
	function automatic logic flit_is_tail(input logic [FLIT_W-1:0] flit);
		return flit[TAIL_BIT];
	endfunction

	// Hop field read as a signed count
	function automatic logic signed [HOP_W-1:0] flit_hop(input logic [FLIT_W-1:0] flit);
		return signed'(flit[HOP_LSB +: HOP_W]);
	endfunction

	// Rebuild a flit from a tail marker and a new hop field
	function automatic logic [FLIT_W-1:0] flit_pack(
		input logic                    tail,
		input logic signed [HOP_W-1:0] hop
	);
		logic [FLIT_W-1:0] flit;

		flit                    = '0;
		flit[TAIL_BIT]          = tail;
		flit[HOP_LSB +: HOP_W]  = hop;
		return flit;
	endfunction

endpackage

//--- output_arbiter.sv
// Packet-locked output arbiter

`timescale 1ns/1ps

module output_arbiter (
	input  logic                                                       clk,
	input  logic                                                       arst_n,
	input  logic [router_pkg::NUM_PORTS-1:0]                           req,
	input  logic [router_pkg::NUM_PORTS-1:0][noc_flit_pkg::FLIT_W-1:0] flit_in,
	output logic [router_pkg::NUM_PORTS-1:0]                           grant,
	output logic                                                       out_valid,
	input  logic                                                       out_ready,
	output logic [noc_flit_pkg::FLIT_W-1:0]                            out_flit
);

	import noc_flit_pkg::*;
	import router_pkg::*;

	logic                  locked;  // Held from head grant to tail transfer
	logic [PORT_IDX_W-1:0] last;    // Last served input, owner while locked
	logic [NUM_PORTS-1:0]  rr_grant;
	logic [PORT_IDX_W-1:0] rr_idx;
	logic [PORT_IDX_W-1:0] sel_idx;
	logic                  tail_xfer;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Round-robin pick, nearest requester after last
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin : rr_pick
		int unsigned idx;

		rr_grant = '0;
		rr_idx   = last;
		// Walk from farthest to nearest so the nearest overwrites
		for (int i = NUM_PORTS; i >= 1; i--) begin
			idx = (int'(last) + i) % NUM_PORTS;
			if (req[idx]) begin
				rr_grant = NUM_PORTS'(1) << idx;
				rr_idx   = PORT_IDX_W'(idx);
			end
		end
	end

	assign grant     = locked ? (req & (NUM_PORTS'(1) << last)) : rr_grant;
	assign sel_idx   = locked ? last : rr_idx;
	assign out_valid = |grant;
	assign out_flit  = flit_in[sel_idx];
	assign tail_xfer = out_valid & out_ready & flit_is_tail(out_flit);

	// Lock and pointer update
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			locked <= 1'b0;
			last   <= PORT_IDX_W'(NUM_PORTS - 1); // Input 0 wins first
		end else if (!locked) begin
			if (out_valid) begin
				last   <= rr_idx;
				locked <= !tail_xfer; // Single-flit packet done at once
			end
		end else if (tail_xfer) begin
			locked <= 1'b0;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	a_grant_onehot: assert property (
		@(posedge clk) disable iff (!arst_n) $onehot0(grant)
	) else $error("output_arbiter: more than one grant");

	// Stalled flit stays on the link until it transfers
	a_out_hold: assert property (
		@(posedge clk) disable iff (!arst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_flit)
	) else $error("output_arbiter: flit changed while stalled");

endmodule

//--- route_ctrl.sv
// Input route controller

`timescale 1ns/1ps

module route_ctrl (
	input  logic                            clk,
	input  logic                            arst_n,
	input  logic [noc_flit_pkg::FLIT_W-1:0] head_flit,
	input  logic                            not_empty,
	output logic                            pop,
	output logic                            req_down,
	output logic                            req_up,
	output logic [noc_flit_pkg::FLIT_W-1:0] fwd_flit,
	input  logic                            grant_down,
	input  logic                            grant_up,
	input  logic                            ready_down,
	input  logic                            ready_up
);

	import noc_flit_pkg::*;
	import router_pkg::*;

	route_state_t state_q;
	route_state_t state_d;

	logic                    tail;
	logic signed [HOP_W-1:0] hop;
	logic                    go_up;
	logic                    xfer_down;
	logic                    xfer_up;

	assign tail  = flit_is_tail(head_flit);
	assign hop   = flit_hop(head_flit);
	assign go_up = (hop > 0); // Zero and negative hops leave downward

	// Flit leaves on an output only with grant and ready there
	assign xfer_down = grant_down & ready_down;
	assign xfer_up   = grant_up & ready_up;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Next state and outputs
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin : route_fsm
		state_d  = state_q;
		pop      = 1'b0;
		req_down = 1'b0;
		req_up   = 1'b0;
		fwd_flit = head_flit; // Body flits pass untouched

		case (state_q)
			IDLE: begin
				if (not_empty) begin
					state_d = PARSE;
				end
			end

			PARSE: begin
				if (!not_empty) begin
					state_d = IDLE; // Nothing waiting after the last tail
				end else if (go_up) begin
					req_up   = 1'b1;
					fwd_flit = flit_pack(tail, hop - 1'b1); // One hop closer
					pop      = xfer_up;
					if (xfer_up) begin
						state_d = tail ? PARSE : SEND_UP;
					end
				end else begin
					req_down = 1'b1;
					// Negated so the downstream node sees a positive distance
					fwd_flit = flit_pack(tail, -hop);
					pop      = xfer_down;
					if (xfer_down) begin
						state_d = tail ? PARSE : SEND_DOWN;
					end
				end
			end

			SEND_DOWN: begin
				req_down = not_empty;        // Gap in the packet drops the request
				pop      = not_empty & xfer_down;
				if (pop && tail) begin
					state_d = PARSE;
				end
			end

			SEND_UP: begin
				req_up = not_empty;
				pop    = not_empty & xfer_up;
				if (pop && tail) begin
					state_d = PARSE;
				end
			end

			default: begin
				state_d = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// A packet targets exactly one output
	a_one_direction: assert property (
		@(posedge clk) disable iff (!arst_n) !(req_down && req_up)
	) else $error("route_ctrl: both outputs requested");

endmodule

//--- router_checker.sv
// Routing scoreboard

`timescale 1ns/1ps

module router_checker #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                            clk,
	input  logic                            arst_n,
	input  logic                            in_valid_0,
	input  logic                            in_ready_0,
	input  logic [noc_flit_pkg::FLIT_W-1:0] in_flit_0,
	input  logic                            in_valid_1,
	input  logic                            in_ready_1,
	input  logic [noc_flit_pkg::FLIT_W-1:0] in_flit_1,
	input  logic                            out_valid_0,
	input  logic                            out_ready_0,
	input  logic [noc_flit_pkg::FLIT_W-1:0] out_flit_0,
	input  logic                            out_valid_1,
	input  logic                            out_ready_1,
	input  logic [noc_flit_pkg::FLIT_W-1:0] out_flit_1,
	input  logic                            end_run,
	input  logic                            timed_out,
	output int                              error_count,
	output int                              out_count
);

	import noc_flit_pkg::*;
	import router_pkg::*;

	logic [FLIT_W-1:0] exp_q [NUM_PORTS*NUM_PORTS][$]; // input * NUM_PORTS + output
	logic              open_pkt [NUM_PORTS]; // Input is inside a packet
	int                dest [NUM_PORTS];     // Output of the open packet
	int                src [NUM_PORTS];      // Owner of each output, -1 between packets
	int                held [NUM_PORTS];     // Flits buffered per input
	int                pending;
	int                full_cycles;
	logic              started;
	logic              reported;

	// Input link, buffer level checked against in_ready
	task automatic take_input(input int p, input logic v, input logic r,
			input logic [FLIT_W-1:0] flit);
		logic signed [HOP_W-1:0] hop;
		logic [FLIT_W-1:0]       exp;

		if (r != (held[p] < FIFO_DEPTH)) begin
			$display("ERROR %0t: in_ready_%0d is %b with %0d flits held", $time, p, r, held[p]);
			error_count++;
		end
		if (!r) begin
			full_cycles++;
		end
		if (v && r) begin
			exp = flit;
			hop = $signed(flit[HOP_W-1:0]);
			if (!open_pkt[p]) begin
				if (hop > 0) begin
					dest[p]        = PORT_UP;
					exp[HOP_W-1:0] = hop - HOP_W'(1); // One hop used up
				end else begin
					dest[p]        = PORT_DOWN;
					exp[HOP_W-1:0] = -hop;
				end
			end
			open_pkt[p] = !flit[TAIL_BIT];
			exp_q[p*NUM_PORTS + dest[p]].push_back(exp);
			held[p]++;
			pending++;
		end
	endtask

	// Output link, owner picked by the head flit
	task automatic take_output(input int o, input logic [FLIT_W-1:0] flit);
		int q;

		for (int p = 0; p < NUM_PORTS; p++) begin
			q = p*NUM_PORTS + o;
			if (src[o] < 0 && exp_q[q].size() != 0 && exp_q[q][0] == flit) begin
				src[o] = p;
			end
		end
		out_count++;
		q = src[o]*NUM_PORTS + o;
		if (src[o] < 0 || exp_q[q].size() == 0) begin
			$display("ERROR %0t: output %0d sent %h, no packet expects it", $time, o, flit);
			error_count++;
		end else begin
			if (exp_q[q][0] != flit) begin
				$display("ERROR %0t: output %0d sent %h, expected %h from input %0d",
					$time, o, flit, exp_q[q][0], src[o]);
				error_count++;
			end
			void'(exp_q[q].pop_front());
			held[src[o]]--;
			pending--;
		end
		if (flit[TAIL_BIT]) begin
			src[o] = -1;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Sampling at the falling edge, links are stable
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always @(negedge clk or negedge arst_n) begin
		if (!arst_n) begin
			foreach (exp_q[i]) begin
				exp_q[i].delete();
			end
			for (int p = 0; p < NUM_PORTS; p++) begin
				open_pkt[p] = 1'b0;
				dest[p]     = PORT_DOWN;
				src[p]      = -1;
				held[p]     = 0;
			end
			pending     = 0;
			full_cycles = 0;
			error_count = 0;
			out_count   = 0;
			started     = 1'b0;
			reported    = 1'b0;
		end else begin
			if (!started && (out_valid_0 || out_valid_1 || !in_ready_0 || !in_ready_1)) begin
				$display("ERROR %0t: links not idle after reset", $time);
				error_count++;
			end
			started = 1'b1;
			take_input(0, in_valid_0, in_ready_0, in_flit_0);
			take_input(1, in_valid_1, in_ready_1, in_flit_1);
			if (out_valid_0 && out_ready_0) take_output(0, out_flit_0);
			if (out_valid_1 && out_ready_1) take_output(1, out_flit_1);
			if (end_run && !reported) begin
				reported = 1'b1;
				if (timed_out) begin
					$display("The run hit its cycle limit before all packets were delivered");
					error_count++;
				end
				if (pending != 0) begin
					$display("%0d flits entered the node and never left it", pending);
					error_count++;
				end
				if (full_cycles == 0) begin
					$display("No input FIFO ever filled, back-pressure was never seen");
					error_count++;
				end
			end
		end
	end

endmodule

//--- router_node.sv
// Linear network node

`timescale 1ns/1ps

module router_node #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                            clk,
	input  logic                            arst_n,
	input  logic                            in_valid_0,
	output logic                            in_ready_0,
	input  logic [noc_flit_pkg::FLIT_W-1:0] in_flit_0,
	input  logic                            in_valid_1,
	output logic                            in_ready_1,
	input  logic [noc_flit_pkg::FLIT_W-1:0] in_flit_1,
	output logic                            out_valid_0,
	input  logic                            out_ready_0,
	output logic [noc_flit_pkg::FLIT_W-1:0] out_flit_0,
	output logic                            out_valid_1,
	input  logic                            out_ready_1,
	output logic [noc_flit_pkg::FLIT_W-1:0] out_flit_1
);

	import noc_flit_pkg::*;
	import router_pkg::*;

	wire                                push_0;
	wire                                push_1;
	wire [FLIT_W-1:0]                   head_flit [NUM_PORTS];
	wire [NUM_PORTS-1:0]                not_empty;
	wire [NUM_PORTS-1:0]                pop;
	wire [NUM_PORTS-1:0][FLIT_W-1:0]    fwd_flit;
	wire [NUM_PORTS-1:0]                req [NUM_PORTS];   // [output][input]
	wire [NUM_PORTS-1:0]                grant [NUM_PORTS]; // [output][input]

	// Link handshake into the buffers
	assign push_0 = in_valid_0 & in_ready_0;
	assign push_1 = in_valid_1 & in_ready_1;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Input side
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	flit_fifo #(.DEPTH(FIFO_DEPTH)) u_fifo_0 (
		.clk(clk), .arst_n(arst_n),
		.push(push_0), .push_flit(in_flit_0), .in_ready(in_ready_0),
		.pop(pop[0]), .head_flit(head_flit[0]), .not_empty(not_empty[0])
	);

	flit_fifo #(.DEPTH(FIFO_DEPTH)) u_fifo_1 (
		.clk(clk), .arst_n(arst_n),
		.push(push_1), .push_flit(in_flit_1), .in_ready(in_ready_1),
		.pop(pop[1]), .head_flit(head_flit[1]), .not_empty(not_empty[1])
	);

	route_ctrl u_route_0 (
		.clk(clk), .arst_n(arst_n),
		.head_flit(head_flit[0]), .not_empty(not_empty[0]), .pop(pop[0]),
		.req_down(req[PORT_DOWN][0]), .req_up(req[PORT_UP][0]), .fwd_flit(fwd_flit[0]),
		.grant_down(grant[PORT_DOWN][0]), .grant_up(grant[PORT_UP][0]),
		.ready_down(out_ready_0), .ready_up(out_ready_1)
	);

	route_ctrl u_route_1 (
		.clk(clk), .arst_n(arst_n),
		.head_flit(head_flit[1]), .not_empty(not_empty[1]), .pop(pop[1]),
		.req_down(req[PORT_DOWN][1]), .req_up(req[PORT_UP][1]), .fwd_flit(fwd_flit[1]),
		.grant_down(grant[PORT_DOWN][1]), .grant_up(grant[PORT_UP][1]),
		.ready_down(out_ready_0), .ready_up(out_ready_1)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Output side
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	output_arbiter u_arb_down (
		.clk(clk), .arst_n(arst_n),
		.req(req[PORT_DOWN]), .flit_in(fwd_flit), .grant(grant[PORT_DOWN]),
		.out_valid(out_valid_0), .out_ready(out_ready_0), .out_flit(out_flit_0)
	);

	output_arbiter u_arb_up (
		.clk(clk), .arst_n(arst_n),
		.req(req[PORT_UP]), .flit_in(fwd_flit), .grant(grant[PORT_UP]),
		.out_valid(out_valid_1), .out_ready(out_ready_1), .out_flit(out_flit_1)
	);

endmodule

//--- router_pkg.sv
// Router structure definitions

package router_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Port map of a linear node
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int NUM_PORTS  = 2;
	localparam int PORT_IDX_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

	localparam int PORT_DOWN = 0; // Toward lower node indices
	localparam int PORT_UP   = 1; // Toward higher node indices

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Route controller states
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef enum logic [1:0] {
		IDLE      = 2'b00, // FIFO empty, nothing requested
		PARSE     = 2'b01, // Head flit at FIFO output
		SEND_DOWN = 2'b10, // Streaming body flits to output 0
		SEND_UP   = 2'b11  // Streaming body flits to output 1
	} route_state_t;

endpackage

//--- sources.f
noc_flit_pkg.sv
router_pkg.sv
flit_fifo.sv
route_ctrl.sv
output_arbiter.sv
router_node.sv
router_checker.sv
tb_router_node.sv

//--- tb_router_node.sv
// Router node testbench

`timescale 1ns/1ps

module tb_router_node;

	import noc_flit_pkg::*;

	localparam int FIFO_DEPTH = 4;
	localparam int NUM_PKTS   = 14;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Packet table with one column per packet
	// Phase 0 runs with ready outputs and phase 1 under back-pressure
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int PKT_PORT  [NUM_PKTS] = '{0, 1, 0, 1, 0, 1, 0, 1, 0, 1, 0, 1, 1, 0};
	localparam int PKT_HOP   [NUM_PKTS] = '{5, -3, 0, 1, 7, 9, -6, -8, 2, 3, -2, -4, 11, -9};
	localparam int PKT_LEN   [NUM_PKTS] = '{1, 1, 3, 4, 3, 2, 2, 3, 8, 6, 5, 4, 1, 3};
	localparam int PKT_TAG   [NUM_PKTS] = '{16, 32, 48, 64, 80, 96, 112, 128,
	                                        144, 160, 176, 192, 208, 224};
	localparam int PKT_PHASE [NUM_PKTS] = '{0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 1, 1, 1, 1};

	function automatic int count_flits();
		int n;

		n = 0;
		for (int i = 0; i < NUM_PKTS; i++) begin
			n += PKT_LEN[i];
		end
		return n;
	endfunction

	localparam int CYCLE_LIMIT = 40 * count_flits() + 200;

	logic              clk = 1'b0;
	logic              arst_n;
	logic              in_valid_0, in_ready_0, in_valid_1, in_ready_1;
	logic [FLIT_W-1:0] in_flit_0, in_flit_1;
	logic              out_valid_0, out_ready_0, out_valid_1, out_ready_1;
	logic [FLIT_W-1:0] out_flit_0, out_flit_1;
	logic              end_run, timed_out;
	int                error_count, out_count;
	int                ready_mode;      // 0 ready, 1 blocked, 2 random
	int                cycle_count = 0;
	integer            seed = 42;
	logic [31:0]       rnd;

	router_node #(.FIFO_DEPTH(FIFO_DEPTH)) u_dut (.*);
	router_checker #(.FIFO_DEPTH(FIFO_DEPTH)) u_chk (.*);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
	end

	// Output back-pressure
	always @(posedge clk) begin
		#2;
		if (ready_mode == 2) begin
			rnd         = $random(seed);
			out_ready_0 = rnd[0];
			out_ready_1 = rnd[1];
		end else begin
			out_ready_0 = (ready_mode == 0);
			out_ready_1 = (ready_mode == 0);
		end
	end

	task automatic drive_link(input int p, input logic v, input logic [FLIT_W-1:0] f);
		if (p == 0) begin
			in_valid_0 = v;
			in_flit_0  = f;
		end else begin
			in_valid_1 = v;
			in_flit_1  = f;
		end
	endtask

	// Holds the flit until in_ready is seen at a falling edge
	task automatic send_flit(input int p, input logic [FLIT_W-1:0] f);
		logic taken;

		taken = 1'b0;
		drive_link(p, 1'b1, f);
		while (!taken) begin
			@(negedge clk);
			taken = (p == 0) ? in_ready_0 : in_ready_1;
			@(posedge clk);
			#2;
		end
		drive_link(p, 1'b0, '0);
	endtask

	task automatic send_packet(input int p, input int hop, input int len, input int tag);
		logic [FLIT_W-1:0] flit;

		for (int k = 0; k < len; k++) begin
			flit                = '0;
			flit[HOP_W-1:0]     = (k == 0) ? HOP_W'(hop) : HOP_W'(tag + k);
			flit[TAIL_BIT]      = (k == len - 1);
			send_flit(p, flit);
		end
	endtask

	task automatic send_port(input int p, input int phase);
		for (int i = 0; i < NUM_PKTS; i++) begin
			if (PKT_PORT[i] == p && PKT_PHASE[i] == phase) begin
				send_packet(p, PKT_HOP[i], PKT_LEN[i], PKT_TAG[i]);
			end
		end
	endtask

	// Both inputs in parallel and then a wait for the node to drain
	task automatic run_phase(input int phase);
		fork
			send_port(0, phase);
			send_port(1, phase);
		join
		while (u_chk.pending != 0) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic finish_run(input logic hit_limit);
		timed_out = hit_limit;
		end_run   = 1'b1;
		@(negedge clk);
		#1;
		$display("Flits delivered %0d, errors %0d", out_count, error_count);
		if (error_count == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	endtask

	initial begin
		arst_n      = 1'b0;
		in_valid_0  = 1'b0;
		in_valid_1  = 1'b0;
		in_flit_0   = '0;
		in_flit_1   = '0;
		out_ready_0 = 1'b1;
		out_ready_1 = 1'b1;
		end_run     = 1'b0;
		timed_out   = 1'b0;
		ready_mode  = 0;
		repeat (16) @(posedge clk);
		#2;
		arst_n = 1'b1;
		repeat (2) @(posedge clk);
		#2;
		run_phase(0);
		@(posedge clk);
		ready_mode = 1; // Outputs blocked so the FIFOs fill
		#2;
		fork
			run_phase(1);
			begin
				repeat (20) @(posedge clk);
				ready_mode = 2;
			end
		join
		finish_run(1'b0);
	end

	// Watchdog
	initial begin
		while (cycle_count < CYCLE_LIMIT) @(posedge clk);
		if (!end_run) finish_run(1'b1);
	end

endmodule
